/* Makefile */
VERILATOR ?= verilator
TOP       ?= blk_selftest_tb
RTL_TOP   ?= blk_selftest_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SHELL := /bin/bash

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation finished without a reported failure"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+logic
logic/blk_pkg.sv
logic/apb_regs.sv
logic/pattern_gen.sv
logic/test_driver.sv
logic/block_store.sv
logic/blk_selftest_top.sv
verification/blk_selftest_tb.sv

/* logic/apb_regs.sv */
// APB3 register block: control, seed, count and status registers,
// and the run start pulse towards the test driver.
`timescale 1ns/100ps
`include "blk_cfg.svh"

module apb_regs import blk_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [`APB_ADDR_BITS-1:0] paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      run_start,
  output logic                      verify_only,
  output word_t                     seed,
  output blk_addr_t                 count,
  input  logic                      running,
  input  logic                      done,
  input  logic                      error,
  input  logic [7:0]                fail_block
);

  logic access;
  logic wr_access;
  logic mapped;

  assign access    = psel && penable;
  assign wr_access = access && pwrite;
  assign mapped    = paddr inside {CTRL_OFS, SEED_OFS, COUNT_OFS, STATUS_OFS};

  assign pready  = 1'b1;              // No wait states.
  assign pslverr = access && !mapped;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      run_start   <= 1'b0;
      verify_only <= 1'b0;
      seed        <= '0;
      count       <= blk_addr_t'(`BLK_COUNT);
    end else begin
      // Start is dropped while a run is active.
      run_start <= wr_access && (paddr == CTRL_OFS) && pwdata[0] && !running;
      if (wr_access) begin
        case (paddr)
          CTRL_OFS: verify_only <= pwdata[1];
          SEED_OFS: begin
            if (!running) begin
              seed <= pwdata;           // Generator reads the seed live.
            end
          end
          COUNT_OFS: begin
            if ((pwdata == 32'd0) || (pwdata > 32'(`BLK_COUNT))) begin
              count <= blk_addr_t'(`BLK_COUNT);
            end else begin
              count <= blk_addr_t'(pwdata);
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (paddr)
      CTRL_OFS:   prdata = {30'd0, verify_only, 1'b0};
      SEED_OFS:   prdata = seed;
      COUNT_OFS:  prdata = 32'(count);
      STATUS_OFS: prdata = {16'd0, fail_block, 5'd0, error, done, running};
      default:    prdata = 32'd0;
    endcase
  end

  // Access phase always follows a setup phase.
  a_apb_setup_first: assert property (
    @(posedge clock) disable iff (reset)
    penable |-> psel && $past(psel && !penable)
  ) else $error("apb_regs: penable without a preceding setup phase");

endmodule

/* logic/blk_cfg.svh */
// Sizing macros for the block self-test subsystem.
// Block, word and address widths, block count and APB address width.
`ifndef BLK_CFG_SVH
`define BLK_CFG_SVH

// One block is BLK_WORDS words of WORD_BITS each.
`define BLK_BITS 4096
`define WORD_BITS 32
`define BLK_WORDS 128

`define BLK_COUNT 4
`define BLK_ADDR_BITS 32

`define APB_ADDR_BITS 8

`endif

/* logic/blk_pkg.sv */
// Shared package: block, word and block address types,
// the test driver FSM states and the APB register offsets.
`include "blk_cfg.svh"

package blk_pkg;

  typedef logic [`BLK_BITS-1:0] block_t;
  typedef logic [`WORD_BITS-1:0] word_t;
  typedef logic [`BLK_ADDR_BITS-1:0] blk_addr_t;

  typedef enum logic [3:0] {
    st_idle,
    st_next_block,
    st_make_pattern,
    st_write_block,
    st_wait_write,
    st_read_block,
    st_wait_read,
    st_compare,
    st_done,
    st_read_error
  } drv_state_t;

  localparam logic [`APB_ADDR_BITS-1:0] CTRL_OFS = 'h00;   // Bit0 start, bit1 verify_only.
  localparam logic [`APB_ADDR_BITS-1:0] SEED_OFS = 'h04;
  localparam logic [`APB_ADDR_BITS-1:0] COUNT_OFS = 'h08;
  localparam logic [`APB_ADDR_BITS-1:0] STATUS_OFS = 'h0C; // Read only.

endpackage

/* logic/blk_selftest_top.sv */
// Top level of the block self-test subsystem: APB register block,
// pattern generator, test driver and block store.
`timescale 1ns/100ps
`include "blk_cfg.svh"

module blk_selftest_top import blk_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [`APB_ADDR_BITS-1:0] paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr
);

  logic       run_start;
  logic       verify_only;
  word_t      seed;
  blk_addr_t  count;
  logic       running;
  logic       done;
  logic       error;
  logic [7:0] fail_block;
  logic       gen_start;
  blk_addr_t  gen_addr;
  logic       gen_ready;
  block_t     pattern;
  logic       rd_en;
  logic       wr_en;
  blk_addr_t  addr;
  block_t     write_data;
  block_t     read_data;
  logic       busy;

  apb_regs u_apb_regs (
    .clock, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr,
    .run_start, .verify_only, .seed, .count,
    .running, .done, .error, .fail_block
  );

  pattern_gen u_pattern_gen (
    .clock, .reset, .gen_start, .gen_addr, .seed, .gen_ready, .pattern
  );

  test_driver u_test_driver (
    .clock, .reset, .run_start, .verify_only, .seed, .count,
    .gen_start, .gen_addr, .gen_ready, .pattern,
    .rd_en, .wr_en, .addr, .write_data, .read_data, .busy,
    .running, .done, .error, .fail_block
  );

  block_store u_block_store (
    .clock, .reset, .rd_en, .wr_en, .addr, .write_data, .busy, .read_data
  );

endmodule

/* logic/block_store.sv */
// Word-serial block store: BLK_COUNT blocks of BLK_WORDS words,
// moved one word per cycle through a block-wide shift register.
`timescale 1ns/100ps
`include "blk_cfg.svh"

module block_store import blk_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      rd_en,
  input  logic      wr_en,
  input  blk_addr_t addr,
  input  block_t    write_data,
  output logic      busy,
  output block_t    read_data
);

  localparam int BLK_IDX_BITS  = $clog2(`BLK_COUNT);
  localparam int WORD_IDX_BITS = $clog2(`BLK_WORDS);
  localparam int CNT_BITS      = WORD_IDX_BITS + 1;

  word_t                                 mem [`BLK_COUNT * `BLK_WORDS];
  logic [BLK_IDX_BITS-1:0]               blk_sel;
  logic [CNT_BITS-1:0]                   word_cnt;
  logic [BLK_IDX_BITS+WORD_IDX_BITS-1:0] mem_addr;
  logic                                  is_write;
  logic                                  accept;
  word_t                                 rd_word;
  block_t                                shift_reg;

  assign accept    = (rd_en || wr_en) && !busy;
  assign mem_addr  = {blk_sel, word_cnt[WORD_IDX_BITS-1:0]};
  assign read_data = shift_reg;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy     <= 1'b0;
      is_write <= 1'b0;
      blk_sel  <= '0;
      word_cnt <= '0;
    end else if (accept) begin
      busy     <= 1'b1;
      is_write <= wr_en;
      blk_sel  <= addr[BLK_IDX_BITS-1:0];   // Upper address bits wrap.
      word_cnt <= '0;
    end else if (busy) begin
      word_cnt <= word_cnt + 1'b1;
      if (word_cnt == CNT_BITS'(`BLK_WORDS)) begin
        busy <= 1'b0;                      // BLK_WORDS+1 busy cycles.
      end
    end
  end

  // Registered read, so a read pass trails the word counter by one cycle.
  always_ff @(posedge clock) begin
    rd_word <= mem[mem_addr];
    if (busy && is_write && !word_cnt[WORD_IDX_BITS]) begin
      mem[mem_addr] <= shift_reg[`WORD_BITS-1:0];
    end
  end

  always_ff @(posedge clock) begin
    if (accept && wr_en) begin
      shift_reg <= write_data;
    end else if (busy && is_write) begin
      shift_reg <= shift_reg >> `WORD_BITS;
    end else if (busy && (word_cnt != '0)) begin
      shift_reg <= {rd_word, shift_reg[`BLK_BITS-1:`WORD_BITS]}; // Word 0 ends lowest.
    end
  end

  a_no_drop: assert property (
    @(posedge clock) disable iff (reset)
    (rd_en || wr_en) && !busy |=> busy
  ) else $error("block_store: request seen while idle was not taken");

endmodule

/* logic/pattern_gen.sv */
// Block pattern generator: 32-bit Fibonacci LFSR, taps 32, 22, 2, 1,
// stepped once per word and shifted into a block register.
`timescale 1ns/100ps
`include "blk_cfg.svh"

module pattern_gen import blk_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      gen_start,
  input  blk_addr_t gen_addr,
  input  word_t     seed,
  output logic      gen_ready,
  output block_t    pattern
);

  localparam int CNT_BITS = $clog2(`BLK_WORDS);

  word_t               lfsr;
  word_t               lfsr_next;
  word_t               seed_mix;
  logic [CNT_BITS-1:0] word_cnt;
  logic                active;

  function automatic word_t lfsr_step(input word_t s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  assign seed_mix  = seed ^ word_t'(gen_addr);
  assign lfsr_next = lfsr_step(lfsr);
  assign gen_ready = !active;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      active   <= 1'b0;
      word_cnt <= '0;
      lfsr     <= word_t'(1);
    end else if (gen_start) begin
      active   <= 1'b1;
      word_cnt <= '0;
      lfsr     <= (seed_mix == '0) ? word_t'(1) : seed_mix; // All zero would lock up.
    end else if (active) begin
      lfsr     <= lfsr_next;
      word_cnt <= word_cnt + 1'b1;
      if (word_cnt == CNT_BITS'(`BLK_WORDS - 1)) begin
        active <= 1'b0;
      end
    end
  end

  // New words enter at the top, so word 0 ends in the low bits.
  always_ff @(posedge clock) begin
    if (active) begin
      pattern <= {lfsr_next, pattern[`BLK_BITS-1:`WORD_BITS]};
    end
  end

  a_start_when_ready: assert property (
    @(posedge clock) disable iff (reset)
    gen_start |-> gen_ready
  ) else $error("pattern_gen: gen_start while a block is still being built");

endmodule

/* logic/test_driver.sv */
// Self-test sequencer: write pass over count blocks, then a read pass
// that regenerates each block and compares it with the stored data.
`timescale 1ns/100ps

module test_driver import blk_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       run_start,
  input  logic       verify_only,
  input  word_t      seed,
  input  blk_addr_t  count,
  output logic       gen_start,
  output blk_addr_t  gen_addr,
  input  logic       gen_ready,
  input  block_t     pattern,
  output logic       rd_en,
  output logic       wr_en,
  output blk_addr_t  addr,
  output block_t     write_data,
  input  block_t     read_data,
  input  logic       busy,
  output logic       running,
  output logic       done,
  output logic       error,
  output logic [7:0] fail_block
);

  drv_state_t state;
  drv_state_t next_state;
  drv_state_t state_ret;
  blk_addr_t  blk_idx;
  blk_addr_t  addr_reg;
  blk_addr_t  count_q;
  logic       write_pass;
  logic       can_start;
  logic       pass_end;
  logic       mismatch;
  block_t     expected;

  assign can_start = run_start && (state inside {st_idle, st_done, st_read_error});
  assign pass_end  = (blk_idx == count_q);
  assign mismatch  = (read_data != expected);

  always_comb begin
    next_state = state;
    gen_start  = 1'b0;
    rd_en      = 1'b0;
    wr_en      = 1'b0;
    case (state)
      st_idle, st_done, st_read_error: begin
        if (run_start) next_state = st_next_block;
      end
      st_next_block: begin
        if (!pass_end) begin
          gen_start  = 1'b1;
          next_state = st_make_pattern;
        end else if (!write_pass) begin
          next_state = st_done;
        end
      end
      st_make_pattern: if (gen_ready) next_state = state_ret;
      st_write_block: begin
        wr_en = 1'b1;                            // Held until the store goes busy.
        if (busy) next_state = st_wait_write;
      end
      st_wait_write: if (!busy) next_state = st_next_block;
      st_read_block: begin
        rd_en = 1'b1;
        if (busy) next_state = st_wait_read;
      end
      st_wait_read: if (!busy) next_state = st_compare;
      st_compare: next_state = mismatch ? st_read_error : st_next_block;
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= st_idle;
      state_ret  <= st_idle;
      blk_idx    <= '0;
      addr_reg   <= '0;
      count_q    <= '0;
      write_pass <= 1'b0;
      fail_block <= '0;
    end else begin
      state <= next_state;
      if (can_start) begin
        blk_idx    <= '0;
        count_q    <= count;
        write_pass <= !verify_only;
        fail_block <= '0;
      end else if (state == st_next_block) begin
        if (!pass_end) begin
          addr_reg  <= blk_idx;
          blk_idx   <= blk_idx + 1'b1;
          state_ret <= write_pass ? st_write_block : st_read_block;
        end else if (write_pass) begin
          write_pass <= 1'b0;                    // Switch to the read pass.
          blk_idx    <= '0;
        end
      end else if ((state == st_compare) && mismatch) begin
        fail_block <= addr_reg[7:0];
      end
    end
  end

  always_ff @(posedge clock) begin
    if ((state == st_make_pattern) && gen_ready) begin
      expected <= pattern;
    end
  end

  assign gen_addr   = blk_idx;
  assign addr       = addr_reg;
  assign write_data = expected;
  assign running    = !(state inside {st_idle, st_done, st_read_error});
  assign done       = (state == st_done);
  assign error      = (state == st_read_error);

  a_one_request: assert property (
    @(posedge clock) disable iff (reset)
    !(rd_en && wr_en)
  ) else $error("test_driver: read and write requested together");

  // The generator takes the seed straight from the register block.
  a_seed_stable: assert property (
    @(posedge clock) disable iff (reset)
    running && $past(running) |-> $stable(seed)
  ) else $error("test_driver: seed changed during a run");

endmodule

/* verification/blk_selftest_tb.sv */
// Testbench for the block self-test subsystem: APB tasks, LFSR stimulus,
// a pattern and store model, register and status checks, cycle timeout.
`timescale 1ns/100ps
`include "blk_cfg.svh"

module blk_selftest_tb import blk_pkg::*;;

  localparam int N_RANDOM       = 4;
  localparam int N_RUNS         = 2 * N_RANDOM + 4;
  localparam int TIMEOUT_CYCLES = N_RUNS * `BLK_COUNT * 2 * (2 * `BLK_WORDS + 16) + 2000;

  logic                      clock;
  logic                      reset;
  logic [`APB_ADDR_BITS-1:0] paddr;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [31:0]               pwdata;
  logic [31:0]               prdata;
  logic                      pready;
  logic                      pslverr;

  int          errors      = 0;
  int          checks      = 0;
  int          cycle_count = 0;
  logic [31:0] prng_state;
  word_t       store_seed [`BLK_COUNT];  // Seed of the last full run that wrote each block.

  blk_selftest_top DUT (
    .clock, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: time %0t, %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Stimulus LFSR, taps 32, 30, 26, 25.
  function automatic logic [31:0] prng_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[29] ^ s[25] ^ s[24]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      prng_state = prng_step(prng_state);
      value      = {value[30:0], prng_state[0]};
    end
  endtask

  // Pattern LFSR, taps 32, 22, 2, 1.
  function automatic word_t pattern_step(input word_t s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic block_t model_block(input word_t seed, input int blk);
    word_t  s;
    block_t b;
    s = seed ^ word_t'(blk);
    if (s == '0) begin
      s = word_t'(1);
    end
    for (int w = 0; w < `BLK_WORDS; w++) begin
      s = pattern_step(s);
      b[w*`WORD_BITS +: `WORD_BITS] = s;
    end
    return b;
  endfunction

  function automatic logic [31:0] clamp_count(input logic [31:0] v);
    return ((v < 1) || (v > `BLK_COUNT)) ? 32'(`BLK_COUNT) : v;
  endfunction

  // Lowest mismatching block wins, so the loop runs downwards.
  function automatic logic [31:0] expect_status(input word_t seed, input int n,
                                                input logic verify);
    logic [31:0] status;
    status = 32'h2;
    if (verify) begin
      for (int b = n - 1; b >= 0; b--) begin
        if (model_block(seed, b) != model_block(store_seed[b], b)) begin
          status = 32'h4 | (32'(b) << 8);
        end
      end
    end
    return status;
  endfunction

  task automatic apb_write(input logic [`APB_ADDR_BITS-1:0] a, input logic [31:0] d);
    @(posedge clock);
    paddr   <= a;
    pwrite  <= 1'b1;
    pwdata  <= d;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clock);
    penable <= 1'b1;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [`APB_ADDR_BITS-1:0] a, output logic [31:0] d,
                          output logic err);
    @(posedge clock);
    paddr   <= a;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);                   // Mid access phase.
    d   = prdata;
    err = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_store(input int n);
    block_t exp;
    int     idx;
    for (int b = 0; b < n; b++) begin
      exp = model_block(store_seed[b], b);
      for (int w = 0; w < `BLK_WORDS; w++) begin
        idx = b * `BLK_WORDS + w;
        check_value($sformatf("mem[%0d]", idx), DUT.u_block_store.mem[idx],
                    exp[w*`WORD_BITS +: `WORD_BITS]);
      end
    end
  endtask

  task automatic start_run(input word_t seed, input logic [31:0] count_val,
                           input logic verify);
    logic [31:0] data;
    logic        err;
    apb_write(SEED_OFS, seed);
    apb_write(COUNT_OFS, count_val);
    apb_read(SEED_OFS, data, err);
    check_value("SEED", data, seed);
    apb_read(COUNT_OFS, data, err);
    check_value("COUNT", data, clamp_count(count_val));
    apb_write(CTRL_OFS, {30'd0, verify, 1'b1});
    apb_read(CTRL_OFS, data, err);
    check_value("CTRL", data, {30'd0, verify, 1'b0});
  endtask

  task automatic finish_run(input word_t seed, input logic [31:0] count_val,
                            input logic verify);
    logic [31:0] status;
    logic        err;
    int          n;
    n = clamp_count(count_val);
    apb_read(STATUS_OFS, status, err);
    check_value("STATUS.running", status[0], 1'b1);
    while (status[0]) begin
      apb_read(STATUS_OFS, status, err);
    end
    check_value("STATUS", status, expect_status(seed, n, verify));
    if (!verify) begin
      for (int b = 0; b < n; b++) begin
        store_seed[b] = seed;
      end
      check_store(n);
    end
  endtask

  initial begin
    logic [31:0] data;
    logic        err;
    logic [31:0] seed;
    logic [31:0] count_val;
    logic [31:0] other;
    prng_state = 32'hf724;
    reset      = 1'b1;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    apb_read(STATUS_OFS, data, err);
    check_value("STATUS", data, 32'h0);
    apb_read(CTRL_OFS, data, err);
    check_value("CTRL", data, 32'h0);
    apb_read(SEED_OFS, data, err);
    check_value("SEED", data, 32'h0);
    apb_read(COUNT_OFS, data, err);
    check_value("COUNT", data, 32'(`BLK_COUNT));
    check_value("pslverr", err, 1'b0);
    check_value("pready", pready, 1'b1);
    apb_read(8'h10, data, err);
    check_value("pslverr", err, 1'b1);

    // Count 0 clamps to the whole store and fills every block.
    take_bits(32, seed);
    start_run(seed, 32'd0, 1'b0);
    finish_run(seed, 32'd0, 1'b0);

    for (int i = 0; i < N_RANDOM; i++) begin
      take_bits(32, seed);
      take_bits(3, count_val);
      start_run(seed, count_val, 1'b0);
      finish_run(seed, count_val, 1'b0);
      start_run(seed, count_val, 1'b1);
      finish_run(seed, count_val, 1'b1);
    end

    take_bits(32, other);
    if (other == '0) begin
      other = 32'h1;
    end
    start_run(seed ^ other, count_val, 1'b1);  // Changed seed.
    finish_run(seed ^ other, count_val, 1'b1);

    // A second start, as verify only, while the run is active.
    take_bits(32, seed);
    start_run(seed, 32'(`BLK_COUNT), 1'b0);
    apb_read(STATUS_OFS, data, err);
    check_value("STATUS.running", data[0], 1'b1);
    apb_write(CTRL_OFS, 32'h3);
    finish_run(seed, 32'(`BLK_COUNT), 1'b0);
    start_run(seed, 32'(`BLK_COUNT), 1'b1);
    finish_run(seed, 32'(`BLK_COUNT), 1'b1);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
